/* verilog/jesd_ctl_pkg.sv */
// JESD204B link controller shared definitions
// Status field widths, qualifier state encoding and default timing
package jesd_ctl_pkg;

	//////////////////////////////////////////////////
	// Status field widths
	//////////////////////////////////////////////////

	// One-based lane select, 0 means no lane
	typedef logic [3:0] lane_chan_t;

	// Lane elastic buffer fill level
	typedef logic [9:0] usedw_t;

	// Lane link error counter
	typedef logic [31:0] err_cnt_t;

	//////////////////////////////////////////////////
	// PHY-ready qualifier states
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		WAIT_PHY  = 2'd0,
		WAIT_SYNC = 2'd1,
		HOLD      = 2'd2,
		READY     = 2'd3
	} rdy_state_t;

	//////////////////////////////////////////////////
	// Default timing
	//////////////////////////////////////////////////

	parameter int DEF_NUM_LANES = 4;

	// Reset windows in power-up counter values
	parameter logic [31:0] DEF_SYS_RST_START  = 32'd100000;
	parameter logic [31:0] DEF_SYS_RST_END    = 32'd110000;
	parameter logic [31:0] DEF_DATA_RST_START = 32'd200000;
	parameter logic [31:0] DEF_DATA_RST_END   = 32'd210000;

	// Debounce length in rst_ctl_clk cycles
	parameter logic [15:0] DEF_READY_HOLD = 16'd1000;

endpackage

/* verilog/gt_reset_sequencer.sv */
// Transceiver reset sequencer
// Counts from power-good and issues the system-reset window,
// then the data-reset window, then flags the sequence as done
`timescale 1ns/1ps

module gt_reset_sequencer #(
	parameter logic [31:0] SYS_RST_START  = jesd_ctl_pkg::DEF_SYS_RST_START,
	parameter logic [31:0] SYS_RST_END    = jesd_ctl_pkg::DEF_SYS_RST_END,
	parameter logic [31:0] DATA_RST_START = jesd_ctl_pkg::DEF_DATA_RST_START,
	parameter logic [31:0] DATA_RST_END   = jesd_ctl_pkg::DEF_DATA_RST_END
) (
	input  logic rst_ctl_clk,
	input  logic pll_locked,
	input  logic gt_powergood_i,
	output logic gt_sys_reset_o,
	output logic gt_data_reset_o,
	output logic seq_done_o
);

	logic [31:0] pwr_cnt;
	logic        cnt_max;
	logic        in_sys_win;
	logic        in_data_win;
	logic        past_data_win;

	//////////////////////////////////////////////////
	// Power-up counter
	//////////////////////////////////////////////////

	// Stops at all ones so the windows never come back
	assign cnt_max = &pwr_cnt;

	always_ff @(posedge rst_ctl_clk or negedge pll_locked) begin
		if (!pll_locked) begin
			pwr_cnt <= '0;
		end else if (!gt_powergood_i) begin
			// Sequence restarts on every power-good loss
			pwr_cnt <= '0;
		end else begin
			pwr_cnt <= pwr_cnt + {31'd0, ~cnt_max};
		end
	end

	//////////////////////////////////////////////////
	// Window comparators
	//////////////////////////////////////////////////

	assign in_sys_win    = (pwr_cnt >= SYS_RST_START) && (pwr_cnt <= SYS_RST_END);
	assign in_data_win   = (pwr_cnt >= DATA_RST_START) && (pwr_cnt <= DATA_RST_END);
	assign past_data_win = (pwr_cnt > DATA_RST_END);

	// Gated by power-good so a drop clears all three on the next edge,
	// before the cleared counter value reaches the comparators
	always_ff @(posedge rst_ctl_clk or negedge pll_locked) begin
		if (!pll_locked) begin
			gt_sys_reset_o  <= 1'b0;
			gt_data_reset_o <= 1'b0;
			seq_done_o      <= 1'b0;
		end else begin
			gt_sys_reset_o  <= gt_powergood_i & in_sys_win;
			gt_data_reset_o <= gt_powergood_i & in_data_win;
			seq_done_o      <= gt_powergood_i & past_data_win;
		end
	end

endmodule

/* verilog/lane_status_monitor.sv */
// Lane status monitor
// Combines the per-lane SYNC~ flags into one ADC SYNC~ and picks
// one lane's fill level and error count by a one-based channel
`timescale 1ns/1ps

module lane_status_monitor #(
	parameter int NUM_LANES = jesd_ctl_pkg::DEF_NUM_LANES
) (
	input  logic                                   rst_ctl_clk,
	input  logic                                   pll_locked,
	input  logic [NUM_LANES-1:0]                   lane_sync_b_i,
	input  jesd_ctl_pkg::usedw_t   [NUM_LANES-1:0] lane_usedw_i,
	input  jesd_ctl_pkg::err_cnt_t [NUM_LANES-1:0] lane_err_i,
	input  jesd_ctl_pkg::lane_chan_t               rx_channel_i,
	output logic                                   adc_sync_b_o,
	output jesd_ctl_pkg::usedw_t                   usedw_o,
	output jesd_ctl_pkg::err_cnt_t                 err_link_rx_o
);

	logic [NUM_LANES-1:0]   lane_hit;
	jesd_ctl_pkg::usedw_t   sel_usedw;
	jesd_ctl_pkg::err_cnt_t sel_err;

	//////////////////////////////////////////////////
	// SYNC~ combining
	//////////////////////////////////////////////////

	// Link counts as synced only when every lane is
	always_ff @(posedge rst_ctl_clk or negedge pll_locked) begin
		if (!pll_locked) begin
			adc_sync_b_o <= 1'b1;
		end else begin
			adc_sync_b_o <= &lane_sync_b_i;
		end
	end

	//////////////////////////////////////////////////
	// Channel decode
	//////////////////////////////////////////////////

	// Lane g answers to code g+1; codes 0 and above NUM_LANES hit nothing
	genvar g;
	generate
		for (g = 0; g < NUM_LANES; g++) begin : g_hit
			assign lane_hit[g] = (rx_channel_i == jesd_ctl_pkg::lane_chan_t'(g + 1));
		end
	endgenerate

	//////////////////////////////////////////////////
	// Status select
	//////////////////////////////////////////////////

	// AND-OR mux, at most one lane_hit bit is set
	always_comb begin
		sel_usedw = '0;
		sel_err   = '0;
		for (int i = 0; i < NUM_LANES; i++) begin
			sel_usedw = sel_usedw | (lane_usedw_i[i] & {$bits(sel_usedw){lane_hit[i]}});
			sel_err   = sel_err | (lane_err_i[i] & {$bits(sel_err){lane_hit[i]}});
		end
	end

	always_ff @(posedge rst_ctl_clk or negedge pll_locked) begin
		if (!pll_locked) begin
			usedw_o       <= '0;
			err_link_rx_o <= '0;
		end else begin
			usedw_o       <= sel_usedw;
			err_link_rx_o <= sel_err;
		end
	end

endmodule

/* verilog/phy_ready_qualifier.sv */
// PHY-ready qualifier
// Releases the link reset once the reset sequence and both transceiver
// reset-done flags agree, then debounces link sync into PHY-ready
`timescale 1ns/1ps

module phy_ready_qualifier #(
	parameter logic [15:0] READY_HOLD = jesd_ctl_pkg::DEF_READY_HOLD
) (
	input  logic rst_ctl_clk,
	input  logic pll_locked,
	input  logic seq_done_i,
	input  logic tx_reset_done_i,
	input  logic rx_reset_done_i,
	input  logic gt_powergood_i,
	input  logic adc_sync_b_i,
	output logic link_rst_n_o,
	output logic phy_ready_o
);

	jesd_ctl_pkg::rdy_state_t state;
	jesd_ctl_pkg::rdy_state_t state_next;
	logic [15:0]              hold_cnt;
	logic                     hold_done;
	logic                     link_ok;

	//////////////////////////////////////////////////
	// Link reset release
	//////////////////////////////////////////////////

	// Reset-done flags count only after the sequence has finished
	assign link_ok = seq_done_i & tx_reset_done_i & rx_reset_done_i & gt_powergood_i;

	always_ff @(posedge rst_ctl_clk or negedge pll_locked) begin
		if (!pll_locked) begin
			link_rst_n_o <= 1'b0;
		end else begin
			link_rst_n_o <= link_ok;
		end
	end

	//////////////////////////////////////////////////
	// Sync debounce FSM
	//////////////////////////////////////////////////

	// Widened so a hold of 0 or 1 still terminates
	assign hold_done = ({1'b0, hold_cnt} + 17'd1) >= {1'b0, READY_HOLD};

	// Follows the next link reset value, so the FSM leaves READY
	// on the same edge that drops link_rst_n_o
	always_comb begin
		state_next = state;
		case (state)
			jesd_ctl_pkg::WAIT_PHY: begin
				if (link_ok) begin
					state_next = jesd_ctl_pkg::WAIT_SYNC;
				end
			end
			jesd_ctl_pkg::WAIT_SYNC: begin
				if (!link_ok) begin
					state_next = jesd_ctl_pkg::WAIT_PHY;
				end else if (adc_sync_b_i) begin
					state_next = jesd_ctl_pkg::HOLD;
				end
			end
			jesd_ctl_pkg::HOLD, jesd_ctl_pkg::READY: begin
				// Loss of either condition backs off at once
				if (!link_ok) begin
					state_next = jesd_ctl_pkg::WAIT_PHY;
				end else if (!adc_sync_b_i) begin
					state_next = jesd_ctl_pkg::WAIT_SYNC;
				end else if (state == jesd_ctl_pkg::HOLD && hold_done) begin
					state_next = jesd_ctl_pkg::READY;
				end
			end
			default: state_next = jesd_ctl_pkg::WAIT_PHY;
		endcase
	end

	always_ff @(posedge rst_ctl_clk or negedge pll_locked) begin
		if (!pll_locked) begin
			state    <= jesd_ctl_pkg::WAIT_PHY;
			hold_cnt <= '0;
		end else begin
			state <= state_next;
			// Counts only while the hold keeps going
			if (state == jesd_ctl_pkg::HOLD && state_next == jesd_ctl_pkg::HOLD) begin
				hold_cnt <= hold_cnt + 16'd1;
			end else begin
				hold_cnt <= '0;
			end
		end
	end

	assign phy_ready_o = (state == jesd_ctl_pkg::READY);

endmodule

/* verilog/jesd_link_ctl.sv */
// JESD204B link bring-up and status controller
// Transceiver reset sequencing, lane status monitoring and
// PHY-ready qualification, all on the reset controller clock
`timescale 1ns/1ps

module jesd_link_ctl #(
	parameter int          NUM_LANES      = jesd_ctl_pkg::DEF_NUM_LANES,
	parameter logic [31:0] SYS_RST_START  = jesd_ctl_pkg::DEF_SYS_RST_START,
	parameter logic [31:0] SYS_RST_END    = jesd_ctl_pkg::DEF_SYS_RST_END,
	parameter logic [31:0] DATA_RST_START = jesd_ctl_pkg::DEF_DATA_RST_START,
	parameter logic [31:0] DATA_RST_END   = jesd_ctl_pkg::DEF_DATA_RST_END,
	parameter logic [15:0] READY_HOLD     = jesd_ctl_pkg::DEF_READY_HOLD
) (
	input  logic                                   rst_ctl_clk,
	input  logic                                   pll_locked,
	// Transceiver status
	input  logic                                   gt_powergood_i,
	input  logic                                   tx_reset_done_i,
	input  logic                                   rx_reset_done_i,
	// Transceiver reset controls
	output logic                                   gt_sys_reset_o,
	output logic                                   gt_data_reset_o,
	// Receive lane status
	input  logic [NUM_LANES-1:0]                   lane_sync_b_i,
	input  jesd_ctl_pkg::usedw_t   [NUM_LANES-1:0] lane_usedw_i,
	input  jesd_ctl_pkg::err_cnt_t [NUM_LANES-1:0] lane_err_i,
	input  jesd_ctl_pkg::lane_chan_t               rx_channel_i,
	output jesd_ctl_pkg::usedw_t                   usedw_o,
	output jesd_ctl_pkg::err_cnt_t                 err_link_rx_o,
	// Link state
	output logic                                   link_rst_n_o,
	output logic                                   adc_sync_b_o,
	output logic                                   phy_ready_o
);

	logic seq_done;
	logic adc_sync_b;

	//////////////////////////////////////////////////
	// Transceiver reset sequence
	//////////////////////////////////////////////////

	gt_reset_sequencer #(
		.SYS_RST_START  (SYS_RST_START),
		.SYS_RST_END    (SYS_RST_END),
		.DATA_RST_START (DATA_RST_START),
		.DATA_RST_END   (DATA_RST_END)
	) u_seq (
		.rst_ctl_clk     (rst_ctl_clk),
		.pll_locked      (pll_locked),
		.gt_powergood_i  (gt_powergood_i),
		.gt_sys_reset_o  (gt_sys_reset_o),
		.gt_data_reset_o (gt_data_reset_o),
		.seq_done_o      (seq_done)
	);

	//////////////////////////////////////////////////
	// Lane status
	//////////////////////////////////////////////////

	lane_status_monitor #(
		.NUM_LANES (NUM_LANES)
	) u_mon (
		.rst_ctl_clk   (rst_ctl_clk),
		.pll_locked    (pll_locked),
		.lane_sync_b_i (lane_sync_b_i),
		.lane_usedw_i  (lane_usedw_i),
		.lane_err_i    (lane_err_i),
		.rx_channel_i  (rx_channel_i),
		.adc_sync_b_o  (adc_sync_b),
		.usedw_o       (usedw_o),
		.err_link_rx_o (err_link_rx_o)
	);

	// Combined SYNC~ also feeds the ready qualifier
	assign adc_sync_b_o = adc_sync_b;

	//////////////////////////////////////////////////
	// Link reset and PHY ready
	//////////////////////////////////////////////////

	phy_ready_qualifier #(
		.READY_HOLD (READY_HOLD)
	) u_qual (
		.rst_ctl_clk     (rst_ctl_clk),
		.pll_locked      (pll_locked),
		.seq_done_i      (seq_done),
		.tx_reset_done_i (tx_reset_done_i),
		.rx_reset_done_i (rx_reset_done_i),
		.gt_powergood_i  (gt_powergood_i),
		.adc_sync_b_i    (adc_sync_b),
		.link_rst_n_o    (link_rst_n_o),
		.phy_ready_o     (phy_ready_o)
	);

endmodule

/* verification/jesd_link_ctl_checker.sv */
// Link controller checker
// Concurrent assertions on the top level reset and ready outputs
`timescale 1ns/1ps

module jesd_link_ctl_checker (
	input logic rst_ctl_clk,
	input logic pll_locked,
	input logic sys_reset_i,
	input logic data_reset_i,
	input logic link_rst_n_i,
	input logic adc_sync_b_i,
	input logic phy_ready_i
);

	//////////////////////////////////////////////////
	// Reset sequence
	//////////////////////////////////////////////////

	// Windows never overlap
	a_resets_exclusive: assert property (@(posedge rst_ctl_clk) disable iff (!pll_locked)
		!(sys_reset_i && data_reset_i))
		else $error("system and data reset are high together");

	//////////////////////////////////////////////////
	// PHY ready
	//////////////////////////////////////////////////

	a_ready_needs_link: assert property (@(posedge rst_ctl_clk) disable iff (!pll_locked)
		phy_ready_i |-> link_rst_n_i)
		else $error("phy_ready_o is high while the link is held in reset");

	// Lost SYNC~ drops ready by the next sample
	a_sync_loss_drops_ready: assert property (@(posedge rst_ctl_clk) disable iff (!pll_locked)
		!adc_sync_b_i |=> !phy_ready_i)
		else $error("phy_ready_o stayed high after adc_sync_b_o went low");

endmodule

bind jesd_link_ctl jesd_link_ctl_checker u_checker (
	.rst_ctl_clk  (rst_ctl_clk),
	.pll_locked   (pll_locked),
	.sys_reset_i  (gt_sys_reset_o),
	.data_reset_i (gt_data_reset_o),
	.link_rst_n_i (link_rst_n_o),
	.adc_sync_b_i (adc_sync_b_o),
	.phy_ready_i  (phy_ready_o)
);

/* verification/jesd_link_ctl_tb.sv */
// Link controller testbench
// Seeded random stimulus checked every cycle against a reference model
`timescale 1ns/1ps

module jesd_link_ctl_tb;

	localparam int          NUM_LANES  = 4;
	localparam logic [31:0] SYS_START  = 32'd10;
	localparam logic [31:0] SYS_END    = 32'd14;
	localparam logic [31:0] DATA_START = 32'd20;
	localparam logic [31:0] DATA_END   = 32'd24;
	localparam logic [15:0] READY_HOLD = 16'd8;
	localparam int          CLK_PERIOD = 10;
	// Cycle budget of each test
	localparam int TOTAL_CYC = 5 + 100 + 200 + 100 + 280;

	logic rst_ctl_clk;
	logic pll_locked;
	logic gt_powergood_i;
	logic tx_reset_done_i;
	logic rx_reset_done_i;
	logic [NUM_LANES-1:0] lane_sync_b_i;
	jesd_ctl_pkg::usedw_t   [NUM_LANES-1:0] lane_usedw_i;
	jesd_ctl_pkg::err_cnt_t [NUM_LANES-1:0] lane_err_i;
	jesd_ctl_pkg::lane_chan_t rx_channel_i;
	logic gt_sys_reset_o;
	logic gt_data_reset_o;
	logic link_rst_n_o;
	logic adc_sync_b_o;
	logic phy_ready_o;
	jesd_ctl_pkg::usedw_t   usedw_o;
	jesd_ctl_pkg::err_cnt_t err_link_rx_o;

	// Reference model state
	logic [31:0] m_cnt;
	logic m_sys, m_data, m_done, m_link, m_adc;
	jesd_ctl_pkg::usedw_t   m_usedw;
	jesd_ctl_pkg::err_cnt_t m_err;
	int good_cnt, bad_cnt, error_count;
	string test_name;
	integer seed;
	logic [31:0] rnd;

	jesd_link_ctl #(
		.NUM_LANES (NUM_LANES), .SYS_RST_START (SYS_START), .SYS_RST_END (SYS_END),
		.DATA_RST_START (DATA_START), .DATA_RST_END (DATA_END), .READY_HOLD (READY_HOLD)
	) u_dut (.*);

	initial begin
		rst_ctl_clk = 1'b0;
		forever #(CLK_PERIOD / 2) rst_ctl_clk = ~rst_ctl_clk;
	end

	initial begin
		#(2 * TOTAL_CYC * CLK_PERIOD);
		$display("timeout: the tests did not finish in time");
		$display("Errors found");
		$fatal(1, "watchdog expired");
	end

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			error_count++;
			$display("error %s %s: expected %0h, actual %0h", test_name, what, exp, act);
			$display("Errors found");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// One clock: model update on the rising edge, compare on the falling edge
	task automatic step();
		int idx;
		@(posedge rst_ctl_clk);
		if (!pll_locked) begin
			{m_cnt, m_sys, m_data, m_done, m_link} = '0;
			m_adc = 1'b1;
			m_usedw = '0;
			m_err = '0;
		end else begin
			m_link = m_done & tx_reset_done_i & rx_reset_done_i & gt_powergood_i;
			m_sys  = gt_powergood_i && m_cnt >= SYS_START && m_cnt <= SYS_END;
			m_data = gt_powergood_i && m_cnt >= DATA_START && m_cnt <= DATA_END;
			m_done = gt_powergood_i && m_cnt > DATA_END;
			if (!gt_powergood_i) m_cnt = '0;
			else if (m_cnt != 32'hFFFF_FFFF) m_cnt = m_cnt + 32'd1;
			m_adc = &lane_sync_b_i;
			idx = int'(rx_channel_i);
			m_usedw = (idx >= 1 && idx <= NUM_LANES) ? lane_usedw_i[idx-1] : '0;
			m_err   = (idx >= 1 && idx <= NUM_LANES) ? lane_err_i[idx-1] : '0;
		end
		@(negedge rst_ctl_clk);
		check("gt_sys_reset_o", 32'(m_sys), 32'(gt_sys_reset_o));
		check("gt_data_reset_o", 32'(m_data), 32'(gt_data_reset_o));
		check("link_rst_n_o", 32'(m_link), 32'(link_rst_n_o));
		check("adc_sync_b_o", 32'(m_adc), 32'(adc_sync_b_o));
		check("usedw_o", 32'(m_usedw), 32'(usedw_o));
		check("err_link_rx_o", m_err, err_link_rx_o);
		// Ready bounds: up within hold plus 3, down within 2 after a loss
		if (m_link && m_adc) begin
			good_cnt++;
			bad_cnt = 0;
		end else begin
			good_cnt = 0;
			bad_cnt++;
		end
		if (good_cnt >= int'(READY_HOLD) + 3) check("phy_ready_o late", 32'd1, 32'(phy_ready_o));
		if (bad_cnt >= 2) check("phy_ready_o after loss", 32'd0, 32'(phy_ready_o));
	endtask

	task automatic randomize_lanes();
		for (int i = 0; i < NUM_LANES; i++) begin
			rnd = $random(seed);
			lane_usedw_i[i] = rnd[9:0];
			rnd = $random(seed);
			lane_err_i[i] = rnd;
		end
		rnd = $random(seed);
		rx_channel_i = {1'b0, rnd[2:0]};
	endtask

	// Counts pulses and pulse widths of both reset windows
	task automatic measure_windows(input int cycles);
		int sys_len, data_len, sys_rise, data_rise;
		logic sys_prev, data_prev;
		{sys_len, data_len, sys_rise, data_rise} = '0;
		sys_prev = gt_sys_reset_o;
		data_prev = gt_data_reset_o;
		repeat (cycles) begin
			step();
			if (gt_sys_reset_o) sys_len++;
			if (gt_data_reset_o) data_len++;
			if (gt_sys_reset_o && !sys_prev) sys_rise++;
			if (gt_data_reset_o && !data_prev) data_rise++;
			sys_prev = gt_sys_reset_o;
			data_prev = gt_data_reset_o;
		end
		check("sys reset pulses", 32'd1, sys_rise);
		check("sys reset width", SYS_END - SYS_START + 32'd1, sys_len);
		check("data reset pulses", 32'd1, data_rise);
		check("data reset width", DATA_END - DATA_START + 32'd1, data_len);
	endtask

	initial begin
		int drop_lane;
		seed = 94;
		error_count = 0;
		good_cnt = 0;
		bad_cnt = 2;
		{pll_locked, gt_powergood_i, tx_reset_done_i, rx_reset_done_i} = '0;
		lane_sync_b_i = '1;
		lane_usedw_i = '0;
		lane_err_i = '0;
		rx_channel_i = '0;

		test_name = "reset_values";
		repeat (3) step();
		pll_locked = 1'b1;
		repeat (2) step();

		test_name = "reset_windows";
		repeat (5) step();
		gt_powergood_i = 1'b1;
		measure_windows(40);
		gt_powergood_i = 1'b0;
		repeat (3) step();
		gt_powergood_i = 1'b1;
		measure_windows(40);

		test_name = "status_select";
		repeat (200) begin
			randomize_lanes();
			step();
		end

		test_name = "sync_combining";
		repeat (100) begin
			rnd = $random(seed);
			lane_sync_b_i = rnd[NUM_LANES-1:0];
			step();
		end

		////////////////////////////////////////////////
		// Link reset and ready
		////////////////////////////////////////////////
		test_name = "link_qualification";
		gt_powergood_i = 1'b0;
		lane_sync_b_i = '1;
		tx_reset_done_i = 1'b1;
		rx_reset_done_i = 1'b1;
		repeat (4) step();
		// Done flags already high, link must wait for the sequence
		gt_powergood_i = 1'b1;
		repeat (50) step();
		check("phy_ready_o after hold", 32'd1, 32'(phy_ready_o));
		rnd = $random(seed);
		drop_lane = int'(rnd[7:0]) % NUM_LANES;
		lane_sync_b_i[drop_lane] = 1'b0;
		repeat (4) step();
		check("phy_ready_o after lane drop", 32'd0, 32'(phy_ready_o));
		lane_sync_b_i = '1;
		repeat (20) step();
		check("phy_ready_o after sync return", 32'd1, 32'(phy_ready_o));
		rx_reset_done_i = 1'b0;
		repeat (4) step();
		check("phy_ready_o after rx done drop", 32'd0, 32'(phy_ready_o));
		rx_reset_done_i = 1'b1;
		repeat (20) step();
		check("phy_ready_o after rx done return", 32'd1, 32'(phy_ready_o));
		repeat (150) begin
			randomize_lanes();
			for (int i = 0; i < NUM_LANES; i++) begin
				rnd = $random(seed);
				lane_sync_b_i[i] = (rnd[5:0] != 6'd0);
			end
			rnd = $random(seed);
			tx_reset_done_i = (rnd[5:0] != 6'd0);
			rx_reset_done_i = (rnd[11:6] != 6'd0);
			step();
		end

		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* jesd_link_ctl.f */
verilog/jesd_ctl_pkg.sv
verilog/gt_reset_sequencer.sv
verilog/lane_status_monitor.sv
verilog/phy_ready_qualifier.sv
verilog/jesd_link_ctl.sv
verification/jesd_link_ctl_checker.sv
verification/jesd_link_ctl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the link controller testbench with Verilator

rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module jesd_link_ctl_tb \
	-f jesd_link_ctl.f -o jesd_link_ctl_sim > build.log 2>&1 ||
	{ echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/jesd_link_ctl_sim > sim.log 2>&1
grep -q "Errors found" sim.log && { echo "Simulation FAILED, see sim.log"; exit 1; }
grep -q "No errors" sim.log && echo "Simulation passed" ||
	{ echo "Simulation FAILED, no result in sim.log"; exit 1; }
